// ==== source/riscv_core_pkg.sv ====
`default_nettype none

package riscv_core_pkg;

  localparam int xlen = 64;
  localparam int imem_depth = 64;

  typedef logic [xlen-1:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [$clog2(imem_depth)-1:0] imem_addr_t;

  // Major opcodes the core executes
  typedef enum logic [6:0] {
    op     = 7'b0110011,
    op_imm = 7'b0010011,
    branch = 7'b1100011,
    system = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_slt
  } alu_op_e;

  // Operand source seen by execute
  typedef enum logic [1:0] {
    fwd_none,
    fwd_ex,
    fwd_wb
  } fwd_sel_e;

endpackage

`default_nettype wire

// ==== source/instr_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_mem (
  input  logic                       clk,
  input  logic                       we,
  input  riscv_core_pkg::imem_addr_t waddr,
  input  riscv_core_pkg::instr_t     wdata,
  input  riscv_core_pkg::imem_addr_t raddr,
  output riscv_core_pkg::instr_t     rdata
);

  import riscv_core_pkg::*;

  instr_t mem [imem_depth];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

  // Overwriting the fetched word is only legal while the fetch address holds still
  a_no_load_under_fetch: assert property (
    @(posedge clk) we && (waddr == raddr) |-> raddr == $past(raddr)
  );

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                     clk,
  input  logic                     reset,
  input  riscv_core_pkg::reg_idx_t rs1,
  input  riscv_core_pkg::reg_idx_t rs2,
  output riscv_core_pkg::word_t    rs1_value,
  output riscv_core_pkg::word_t    rs2_value,
  input  logic                     we,
  input  riscv_core_pkg::reg_idx_t wd_idx,
  input  riscv_core_pkg::word_t    wd_value
);

  import riscv_core_pkg::*;

  // x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wd_idx != '0) begin
      regs[wd_idx] <= wd_value;
    end
  end

  assign rs1_value = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_value = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  logic                       halt,
  input  logic                       branch_taken,
  input  riscv_core_pkg::word_t      branch_target,
  output riscv_core_pkg::imem_addr_t imem_raddr,
  output logic                       if_valid,
  output riscv_core_pkg::word_t      if_pc,
  input  riscv_core_pkg::instr_t     imem_rdata,
  output riscv_core_pkg::instr_t     if_instr
);

  import riscv_core_pkg::*;

  logic  running;
  logic  fetching;
  word_t pc;

  // First fetch goes out in the start cycle itself
  assign fetching   = start || running;
  assign imem_raddr = pc[$bits(imem_addr_t)+1:2];
  assign if_instr   = imem_rdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      running  <= 1'b0;
      if_valid <= 1'b0;
      pc       <= '0;
    end else begin
      if (halt) begin
        running <= 1'b0;
      end else if (start) begin
        running <= 1'b1;
      end
      // A redirect or halt kills the fetch issued this cycle
      if_valid <= fetching && !branch_taken && !halt;
      if (branch_taken) begin
        pc <= branch_target;
      end else if (fetching && !halt) begin
        pc <= pc + word_t'(4);
      end
    end
  end

  always_ff @(posedge clk) begin
    if_pc <= pc;
  end

  a_start_not_during_branch: assert property (
    @(posedge clk) disable iff (reset) !(start && branch_taken)
  );

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     if_valid,
  input  riscv_core_pkg::word_t    if_pc,
  input  riscv_core_pkg::instr_t   if_instr,
  input  logic                     flush,
  output riscv_core_pkg::reg_idx_t rs1,
  output riscv_core_pkg::reg_idx_t rs2,
  input  riscv_core_pkg::word_t    rs1_value,
  input  riscv_core_pkg::word_t    rs2_value,
  input  logic                     ex_valid,
  input  riscv_core_pkg::reg_idx_t ex_rd,
  input  logic                     wb_valid,
  input  riscv_core_pkg::reg_idx_t wb_rd,
  input  riscv_core_pkg::word_t    wb_value,
  output logic                     halt,
  output logic                     id_valid,
  output riscv_core_pkg::word_t    id_pc,
  output riscv_core_pkg::word_t    id_op1,
  output riscv_core_pkg::word_t    id_op2,
  output riscv_core_pkg::word_t    id_imm,
  output riscv_core_pkg::fwd_sel_e id_fwd1,
  output riscv_core_pkg::fwd_sel_e id_fwd2,
  output riscv_core_pkg::alu_op_e  id_alu_op,
  output logic                     id_use_imm,
  output logic                     id_is_branch,
  output logic                     id_branch_ne,
  output riscv_core_pkg::reg_idx_t id_rd,
  output logic                     id_writes_rd
);

  import riscv_core_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd;
  word_t      imm_i;
  word_t      imm_b;
  logic       known;
  logic       writes_rd;
  logic       use_imm;
  logic       is_branch;
  logic       is_ebreak;
  alu_op_e    alu_op;

  // Producer in execute wins over the one in the execute result register
  function automatic fwd_sel_e pick_fwd(reg_idx_t src);
    if (src == '0) begin
      return fwd_none;
    end else if (id_valid && id_writes_rd && id_rd == src) begin
      return fwd_ex;
    end else if (ex_valid && ex_rd == src) begin
      return fwd_wb;
    end
    return fwd_none;
  endfunction

  // Value being written into the register file this very edge
  function automatic word_t bypass_wb(reg_idx_t src, word_t rf_value);
    if (wb_valid && src != '0 && wb_rd == src) begin
      return wb_value;
    end
    return rf_value;
  endfunction

  assign funct3 = if_instr[14:12];
  assign funct7 = if_instr[31:25];
  assign rd     = if_instr[11:7];
  assign rs1    = if_instr[19:15];
  assign rs2    = if_instr[24:20];
  assign imm_i  = {{52{if_instr[31]}}, if_instr[31:20]};
  assign imm_b  = {{52{if_instr[31]}}, if_instr[7], if_instr[30:25], if_instr[11:8], 1'b0};

  always_comb begin
    known     = 1'b0;
    writes_rd = 1'b0;
    use_imm   = 1'b0;
    is_branch = 1'b0;
    is_ebreak = 1'b0;
    alu_op    = alu_add;
    case (opcode_e'(if_instr[6:0]))
      op: begin
        known = (funct7 == 7'h00 && funct3 != 3'b011) || (funct7 == 7'h20 && funct3 == 3'b000);
        writes_rd = known;
        case (funct3)
          3'b000:  alu_op = funct7[5] ? alu_sub : alu_add;
          3'b001:  alu_op = alu_sll;
          3'b010:  alu_op = alu_slt;
          3'b100:  alu_op = alu_xor;
          3'b101:  alu_op = alu_srl;
          3'b110:  alu_op = alu_or;
          default: alu_op = alu_and;
        endcase
      end
      op_imm: begin
        known     = funct3 inside {3'b000, 3'b100, 3'b110, 3'b111};
        writes_rd = known;
        use_imm   = 1'b1;
        case (funct3)
          3'b100:  alu_op = alu_xor;
          3'b110:  alu_op = alu_or;
          3'b111:  alu_op = alu_and;
          default: alu_op = alu_add;
        endcase
      end
      branch: begin
        // beq and bne only
        is_branch = funct3[2:1] == 2'b00;
        known     = is_branch;
      end
      system: begin
        is_ebreak = funct3 == 3'b000 && if_instr[31:20] == 12'h001 && rs1 == '0 && rd == '0;
        known     = is_ebreak;
      end
      default: known = 1'b0;
    endcase
  end

  assign halt = if_valid && !flush && is_ebreak;

  // Only effective instructions go valid, so ebreak is the valid one
  // that neither writes nor branches
  always_ff @(posedge clk) begin
    if (reset) begin
      id_valid     <= 1'b0;
      id_writes_rd <= 1'b0;
      id_is_branch <= 1'b0;
    end else begin
      id_valid     <= if_valid && !flush && known;
      id_writes_rd <= writes_rd;
      id_is_branch <= is_branch;
    end
  end

  always_ff @(posedge clk) begin
    id_pc        <= if_pc;
    id_op1       <= bypass_wb(rs1, rs1_value);
    id_op2       <= bypass_wb(rs2, rs2_value);
    id_imm       <= is_branch ? imm_b : imm_i;
    id_fwd1      <= pick_fwd(rs1);
    id_fwd2      <= pick_fwd(rs2);
    id_alu_op    <= alu_op;
    id_use_imm   <= use_imm;
    id_branch_ne <= funct3[0];
    id_rd        <= rd;
  end

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     id_valid,
  input  riscv_core_pkg::word_t    id_pc,
  input  riscv_core_pkg::word_t    id_op1,
  input  riscv_core_pkg::word_t    id_op2,
  input  riscv_core_pkg::word_t    id_imm,
  input  riscv_core_pkg::fwd_sel_e id_fwd1,
  input  riscv_core_pkg::fwd_sel_e id_fwd2,
  input  riscv_core_pkg::alu_op_e  id_alu_op,
  input  logic                     id_use_imm,
  input  logic                     id_is_branch,
  input  logic                     id_branch_ne,
  input  riscv_core_pkg::reg_idx_t id_rd,
  input  logic                     id_writes_rd,
  input  riscv_core_pkg::word_t    wb_value,
  output logic                     ex_valid,
  output riscv_core_pkg::reg_idx_t ex_rd,
  output riscv_core_pkg::word_t    ex_result,
  output logic                     ex_halt,
  output logic                     branch_taken,
  output riscv_core_pkg::word_t    branch_target
);

  import riscv_core_pkg::*;

  word_t      src1;
  word_t      src2;
  word_t      alu_b;
  word_t      alu_y;
  logic [5:0] shamt;

  function automatic word_t select_src(fwd_sel_e sel, word_t reg_value, word_t ex_value,
                                       word_t wb_val);
    case (sel)
      fwd_ex:  return ex_value;
      fwd_wb:  return wb_val;
      default: return reg_value;
    endcase
  endfunction

  assign src1  = select_src(id_fwd1, id_op1, ex_result, wb_value);
  assign src2  = select_src(id_fwd2, id_op2, ex_result, wb_value);
  assign alu_b = id_use_imm ? id_imm : src2;
  assign shamt = alu_b[5:0];

  always_comb begin
    case (id_alu_op)
      alu_sub: alu_y = src1 - alu_b;
      alu_and: alu_y = src1 & alu_b;
      alu_or:  alu_y = src1 | alu_b;
      alu_xor: alu_y = src1 ^ alu_b;
      alu_sll: alu_y = src1 << shamt;
      alu_srl: alu_y = src1 >> shamt;
      alu_slt: alu_y = word_t'($signed(src1) < $signed(alu_b));
      default: alu_y = src1 + alu_b;
    endcase
  end

  // bne flips the equality test
  assign branch_taken  = id_valid && id_is_branch && ((src1 == src2) != id_branch_ne);
  assign branch_target = id_pc + id_imm;

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid <= 1'b0;
      ex_halt  <= 1'b0;
    end else begin
      ex_valid <= id_valid && id_writes_rd;
      ex_halt  <= id_valid && !id_writes_rd && !id_is_branch;
    end
  end

  always_ff @(posedge clk) begin
    ex_rd     <= id_rd;
    ex_result <= alu_y;
  end

  // A taken branch squashes the instruction in decode
  a_taken_branch_squashes: assert property (
    @(posedge clk) disable iff (reset) branch_taken |=> !id_valid
  );

endmodule

`default_nettype wire

// ==== source/writeback_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     ex_valid,
  input  riscv_core_pkg::reg_idx_t ex_rd,
  input  riscv_core_pkg::word_t    ex_result,
  input  logic                     ex_halt,
  output logic                     wb_valid,
  output riscv_core_pkg::reg_idx_t wb_rd,
  output riscv_core_pkg::word_t    wb_value,
  output logic                     done
);

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
      done     <= 1'b0;
    end else begin
      // No strobe for x0 and nothing once the program has ended
      wb_valid <= ex_valid && ex_rd != '0 && !done;
      if (ex_halt) begin
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    wb_rd    <= ex_rd;
    wb_value <= ex_result;
  end

endmodule

`default_nettype wire

// ==== source/riscv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_core (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  logic                       imem_we,
  input  riscv_core_pkg::imem_addr_t imem_addr,
  input  riscv_core_pkg::instr_t     imem_wdata,
  output logic                       wb_valid,
  output riscv_core_pkg::reg_idx_t   wb_rd,
  output riscv_core_pkg::word_t      wb_value,
  output logic                       done
);

  import riscv_core_pkg::*;

  imem_addr_t fetch_addr;
  instr_t     fetch_data;
  instr_t     if_instr;
  logic       if_valid, halt, branch_taken;
  logic       id_valid, id_use_imm, id_is_branch, id_branch_ne, id_writes_rd;
  logic       ex_valid, ex_halt;
  word_t      if_pc, branch_target, rs1_value, rs2_value, ex_result;
  word_t      id_pc, id_op1, id_op2, id_imm;
  reg_idx_t   rs1, rs2, id_rd, ex_rd;
  fwd_sel_e   id_fwd1, id_fwd2;
  alu_op_e    id_alu_op;

  instr_mem instr_mem_i (
    .clk,
    .we   (imem_we),
    .waddr(imem_addr),
    .wdata(imem_wdata),
    .raddr(fetch_addr),
    .rdata(fetch_data)
  );

  reg_file reg_file_i (
    .clk,
    .reset,
    .rs1,
    .rs2,
    .rs1_value,
    .rs2_value,
    .we      (wb_valid),
    .wd_idx  (wb_rd),
    .wd_value(wb_value)
  );

  fetch_stage fetch_stage_i (
    .clk,
    .reset,
    .start,
    .halt,
    .branch_taken,
    .branch_target,
    .imem_raddr(fetch_addr),
    .if_valid,
    .if_pc,
    .imem_rdata(fetch_data),
    .if_instr
  );

  decode_stage decode_stage_i (
    .clk,
    .reset,
    .if_valid,
    .if_pc,
    .if_instr,
    .flush(branch_taken),
    .rs1,
    .rs2,
    .rs1_value,
    .rs2_value,
    .ex_valid,
    .ex_rd,
    .wb_valid,
    .wb_rd,
    .wb_value,
    .halt,
    .id_valid,
    .id_pc,
    .id_op1,
    .id_op2,
    .id_imm,
    .id_fwd1,
    .id_fwd2,
    .id_alu_op,
    .id_use_imm,
    .id_is_branch,
    .id_branch_ne,
    .id_rd,
    .id_writes_rd
  );

  execute_stage execute_stage_i (
    .clk,
    .reset,
    .id_valid,
    .id_pc,
    .id_op1,
    .id_op2,
    .id_imm,
    .id_fwd1,
    .id_fwd2,
    .id_alu_op,
    .id_use_imm,
    .id_is_branch,
    .id_branch_ne,
    .id_rd,
    .id_writes_rd,
    .wb_value,
    .ex_valid,
    .ex_rd,
    .ex_result,
    .ex_halt,
    .branch_taken,
    .branch_target
  );

  writeback_stage writeback_stage_i (
    .clk,
    .reset,
    .ex_valid,
    .ex_rd,
    .ex_result,
    .ex_halt,
    .wb_valid,
    .wb_rd,
    .wb_value,
    .done
  );

endmodule

`default_nettype wire

// ==== dv/riscv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_core_tb;

  import riscv_core_pkg::*;

  typedef struct packed {
    instr_t   instr;
    bit       writes;
    reg_idx_t rd;
    word_t    value;
  } row_t;

  logic       clk;
  logic       reset;
  logic       start;
  logic       imem_we;
  imem_addr_t imem_addr;
  instr_t     imem_wdata;
  logic       wb_valid;
  reg_idx_t   wb_rd;
  word_t      wb_value;
  logic       done;

  row_t     program_rows[$];
  reg_idx_t write_rd[$];
  word_t    write_value[$];
  int       writes_seen;
  bit       started;

  riscv_core riscv_core_i (
    .clk,
    .reset,
    .start,
    .imem_we,
    .imem_addr,
    .imem_wdata,
    .wb_valid,
    .wb_rd,
    .wb_value,
    .done
  );

  // 4 ns period
  always #2 clk = ~clk;

  function automatic instr_t reg_reg_instr(logic [6:0] funct7, logic [2:0] funct3, int rd,
                                           int rs1, int rs2);
    return {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], 7'b0110011};
  endfunction

  function automatic instr_t imm_instr(logic [2:0] funct3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], funct3, rd[4:0], 7'b0010011};
  endfunction

  // B-type scatters the offset bits around the register fields
  function automatic instr_t branch_instr(logic [2:0] funct3, int rs1, int rs2, int offset);
    return {offset[12], offset[10:5], rs2[4:0], rs1[4:0], funct3, offset[4:1], offset[11],
            7'b1100011};
  endfunction

  task automatic expect_write(instr_t instr, int rd, word_t value);
    row_t row;
    row.instr  = instr;
    row.writes = 1'b1;
    row.rd     = rd[4:0];
    row.value  = value;
    program_rows.push_back(row);
  endtask

  task automatic no_write(instr_t instr);
    row_t row;
    row.instr  = instr;
    row.writes = 1'b0;
    row.rd     = '0;
    row.value  = '0;
    program_rows.push_back(row);
  endtask

  task automatic check_value(string name, word_t got, word_t expected);
    if (got !== expected) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopping on first error");
    end
  endtask

  // One row per memory slot, in program order
  task automatic build_program();
    expect_write(imm_instr(3'b000, 1, 0, 5), 1, 64'd5);
    expect_write(imm_instr(3'b000, 2, 0, -3), 2, 64'hFFFF_FFFF_FFFF_FFFD);
    // add takes x2 from the previous and x1 from two back
    expect_write(reg_reg_instr(7'h00, 3'b000, 3, 1, 2), 3, 64'd2);
    expect_write(reg_reg_instr(7'h20, 3'b000, 4, 1, 2), 4, 64'd8);
    expect_write(reg_reg_instr(7'h00, 3'b111, 5, 1, 2), 5, 64'd5);
    expect_write(reg_reg_instr(7'h00, 3'b110, 6, 1, 2), 6, 64'hFFFF_FFFF_FFFF_FFFD);
    expect_write(reg_reg_instr(7'h00, 3'b100, 7, 1, 2), 7, 64'hFFFF_FFFF_FFFF_FFF8);
    expect_write(reg_reg_instr(7'h00, 3'b001, 8, 1, 4), 8, 64'h500);
    expect_write(reg_reg_instr(7'h00, 3'b101, 9, 2, 1), 9, 64'h07FF_FFFF_FFFF_FFFF);
    // slt both ways round
    expect_write(reg_reg_instr(7'h00, 3'b010, 10, 2, 1), 10, 64'd1);
    expect_write(reg_reg_instr(7'h00, 3'b010, 11, 1, 2), 11, 64'd0);
    expect_write(imm_instr(3'b111, 12, 7, 'hF0), 12, 64'hF0);
    expect_write(imm_instr(3'b110, 13, 12, 'h0F), 13, 64'hFF);
    expect_write(imm_instr(3'b100, 14, 13, -1), 14, 64'hFFFF_FFFF_FFFF_FF00);
    // addi x0 is dropped, then x0 reads back as zero
    no_write(imm_instr(3'b000, 0, 1, 7));
    expect_write(reg_reg_instr(7'h00, 3'b000, 15, 0, 1), 15, 64'd5);
    // Shift amount above 31
    expect_write(imm_instr(3'b000, 17, 0, 40), 17, 64'd40);
    expect_write(reg_reg_instr(7'h00, 3'b001, 16, 1, 17), 16, 64'h0000_0500_0000_0000);
    // beq taken over two slots
    no_write(branch_instr(3'b000, 1, 15, 12));
    no_write(imm_instr(3'b000, 18, 0, 1));
    no_write(imm_instr(3'b000, 19, 0, 2));
    no_write(branch_instr(3'b001, 1, 1, 8));
    expect_write(imm_instr(3'b000, 20, 0, 'h7FF), 20, 64'h7FF);
    // Taken bne with x20 forwarded from the previous instruction
    no_write(branch_instr(3'b001, 20, 0, 12));
    no_write(imm_instr(3'b000, 21, 0, 3));
    no_write(imm_instr(3'b000, 22, 0, 4));
    no_write(branch_instr(3'b000, 20, 1, 8));
    expect_write(imm_instr(3'b000, 23, 20, 1), 23, 64'h800);
    // ebreak followed by two words that must never run
    no_write(32'h0010_0073);
    no_write(imm_instr(3'b000, 24, 0, 9));
    no_write(imm_instr(3'b000, 25, 0, 10));
  endtask

  // Writeback monitor samples away from the active edge
  always @(negedge clk) begin
    if (!reset) begin
      if (!started) begin
        check_value("wb_valid", word_t'(wb_valid), '0);
        check_value("done", word_t'(done), '0);
      end else if (wb_valid) begin
        if (writes_seen >= write_rd.size()) begin
          $display("Unexpected write to x%0d at %0t after all expected writes", wb_rd, $time);
          $display("TESTBENCH FAILED");
          $fatal(1, "extra register write");
        end else begin
          check_value("wb_rd", word_t'(wb_rd), word_t'(write_rd[writes_seen]));
          check_value("wb_value", wb_value, write_value[writes_seen]);
          writes_seen++;
        end
      end
    end
  end

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    start       = 1'b0;
    imem_we     = 1'b0;
    imem_addr   = '0;
    imem_wdata  = '0;
    started     = 1'b0;
    writes_seen = 0;
    build_program();
    foreach (program_rows[i]) begin
      if (program_rows[i].writes) begin
        write_rd.push_back(program_rows[i].rd);
        write_value.push_back(program_rows[i].value);
      end
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    foreach (program_rows[i]) begin
      @(posedge clk);
      imem_we    <= 1'b1;
      imem_addr  <= imem_addr_t'(i);
      imem_wdata <= program_rows[i].instr;
    end
    @(posedge clk);
    imem_we <= 1'b0;
    // Idle cycles before start
    repeat (3) @(posedge clk);
    start   <= 1'b1;
    started = 1'b1;
    @(posedge clk);
    start <= 1'b0;
    while (!done) begin
      @(negedge clk);
    end
    // done is sticky
    repeat (8) begin
      @(negedge clk);
      check_value("done", word_t'(done), word_t'(1));
    end
    check_value("write count", word_t'(writes_seen), word_t'(write_rd.size()));
    $display("TESTBENCH PASSED");
    $finish;
  end

  // Watchdog allows one cycle per instruction plus margin
  initial begin
    wait (started);
    #((program_rows.size() + 20) * 4);
    $display("Timeout: done never rose within %0d cycles of start", program_rows.size() + 20);
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== riscv_core.f ====
source/riscv_core_pkg.sv
source/instr_mem.sv
source/reg_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/writeback_stage.sv
source/riscv_core.sv
dv/riscv_core_tb.sv

// ==== Bender.yml ====
package:
  name: riscv_core

sources:
  - source/riscv_core_pkg.sv
  - source/instr_mem.sv
  - source/reg_file.sv
  - source/fetch_stage.sv
  - source/decode_stage.sv
  - source/execute_stage.sv
  - source/writeback_stage.sv
  - source/riscv_core.sv
  - target: simulation
    files:
      - dv/riscv_core_tb.sv
